/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module burst_mux_tb -o burst_mux_sim
	./obj_dir/burst_mux_sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* design/beat_if.sv */
`timescale 1ns/10ps

// Valid/ready beat link between two blocks of the multiplexer
// A beat moves on a rising clk with valid and ready both high
interface beat_if;

    logic                 valid;
    logic                 ready;
    mux_types_pkg::data_t data;
    // Marks the final beat of a burst
    logic                 last;

    // Producer side of the link
    modport src
    (
        output valid,
        output data,
        output last,
        input  ready
    );

    // Consumer side of the link
    modport dst
    (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface : beat_if

/* design/burst_mux_top.sv */
`timescale 1ns/10ps

// Four-client burst multiplexer
// Ingress steering, one queue per client, egress arbitration
module burst_mux_top
    (
        input  logic                   clk,
        input  logic                   rst_n,

        // Ingress stream
        input  logic                   in_valid,
        output logic                   in_ready,
        input  mux_types_pkg::client_t in_client,
        input  mux_types_pkg::data_t   in_data,
        input  logic                   in_last,

        // Egress stream
        output logic                   out_valid,
        input  logic                   out_ready,
        output mux_types_pkg::client_t out_client,
        output mux_types_pkg::data_t   out_data,
        output logic                   out_last
    );

// ======================================================================
// Links

    // Steering block to queues
    beat_if q_in  [mux_cfg_pkg::NUM_CLIENTS] ();
    // Queues to egress block
    beat_if q_out [mux_cfg_pkg::NUM_CLIENTS] ();

// ======================================================================
// Instances

    ingress_steer u_ingress_steer
        (
            .in_valid  (in_valid),
            .in_ready  (in_ready),
            .in_client (in_client),
            .in_data   (in_data),
            .in_last   (in_last),
            .q         (q_in)
        );

    for (genvar i = 0; i < mux_cfg_pkg::NUM_CLIENTS; i++)
        begin : g_queue
            client_queue u_client_queue
                (
                    .clk   (clk),
                    .rst_n (rst_n),
                    .wr    (q_in[i]),
                    .rd    (q_out[i])
                );
        end : g_queue

    egress_merge u_egress_merge
        (
            .clk        (clk),
            .rst_n      (rst_n),
            .q          (q_out),
            .out_valid  (out_valid),
            .out_ready  (out_ready),
            .out_client (out_client),
            .out_data   (out_data),
            .out_last   (out_last)
        );

endmodule : burst_mux_top

/* design/client_queue.sv */
`timescale 1ns/10ps

// Circular FIFO holding the beats of one client
// Head entry is always presented on rd
module client_queue
    (
        input  logic clk,
        input  logic rst_n,

        beat_if.dst  wr,
        beat_if.src  rd
    );

// ======================================================================
// Declarations

    // Slot index and occupancy widths
    // Occupancy needs one more value than the slot index
    typedef logic [$clog2(mux_cfg_pkg::QUEUE_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(mux_cfg_pkg::QUEUE_DEPTH+1)-1:0] cnt_t;

    // Storage, no reset on the payload
    mux_types_pkg::data_t data_mem [mux_cfg_pkg::QUEUE_DEPTH];
    logic                 last_mem [mux_cfg_pkg::QUEUE_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    logic push;
    logic pop;

// ======================================================================
// Handshakes

    // Ready is not full only
    // Independent of rd.ready, so no path through the queue
    assign wr.ready = (count != cnt_t'(mux_cfg_pkg::QUEUE_DEPTH));
    assign rd.valid = (count != '0);

    assign push = wr.valid && wr.ready;
    assign pop  = rd.valid && rd.ready;

    // Head entry
    assign rd.data = data_mem[rd_ptr];
    assign rd.last = last_mem[rd_ptr];

// ======================================================================
// Storage write

    always_ff @(posedge clk)
        begin
            if (push)
                begin
                    data_mem[wr_ptr] <= wr.data;
                    last_mem[wr_ptr] <= wr.last;
                end
        end

// ======================================================================
// Pointers and occupancy

    always_ff @(posedge clk, negedge rst_n)
        begin
            if (!rst_n)
                begin
                    wr_ptr <= '0;
                    rd_ptr <= '0;
                    count  <= '0;
                end
            else
                begin
                    if (push)
                        wr_ptr <= next_ptr(wr_ptr);
                    if (pop)
                        rd_ptr <= next_ptr(rd_ptr);
                    // Simultaneous push and pop leaves the count alone
                    if (push && !pop)
                        count <= count + cnt_t'(1);
                    else if (pop && !push)
                        count <= count - cnt_t'(1);
                end
        end

    // Advance with wrap at the last slot
    // Works for depths that are not a power of two
    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == ptr_t'(mux_cfg_pkg::QUEUE_DEPTH - 1))
            return '0;
        return ptr + ptr_t'(1);
    endfunction

endmodule : client_queue

/* design/egress_merge.sv */
`timescale 1ns/10ps

// Drains the client queues onto one output stream
// A grant covers a whole burst up to its last beat
module egress_merge
    (
        input  logic                   clk,
        input  logic                   rst_n,

        beat_if.dst                    q [mux_cfg_pkg::NUM_CLIENTS],

        output logic                   out_valid,
        input  logic                   out_ready,
        output mux_types_pkg::client_t out_client,
        output mux_types_pkg::data_t   out_data,
        output logic                   out_last
    );

// ======================================================================
// Declarations

    mux_types_pkg::client_mask_t req;
    mux_types_pkg::client_mask_t gnt;
    mux_types_pkg::data_t        q_data [mux_cfg_pkg::NUM_CLIENTS];
    mux_types_pkg::client_mask_t q_last;

    logic hold;
    logic xfer;
    // Some beat of the granted burst has already left
    logic burst_open;

// ======================================================================
// Queue side

    for (genvar i = 0; i < mux_cfg_pkg::NUM_CLIENTS; i++)
        begin : g_gather
            assign req[i]    = q[i].valid;
            assign q_data[i] = q[i].data;
            assign q_last[i] = q[i].last;
            // Only the granted queue sees the output ready
            assign q[i].ready = out_ready && gnt[i];
        end : g_gather

// ======================================================================
// Output mux

    // One-hot grant to a client number
    always_comb
        begin
            out_client = '0;
            for (int i = 0; i < mux_cfg_pkg::NUM_CLIENTS; i++)
                if (gnt[i])
                    out_client = mux_types_pkg::client_t'(i);
        end

    assign out_valid = (gnt != '0) && req[out_client];
    assign out_data  = q_data[out_client];
    assign out_last  = q_last[out_client];

    assign xfer = out_valid && out_ready;

// ======================================================================
// Burst lock

    // Release on the last beat so the next grant lands at the same edge
    // A lone requester may be granted again after its queue ran dry
    // With nothing sent yet and nothing waiting, that grant is let go
    assign hold = (gnt != '0) && !(xfer && out_last) && (burst_open || out_valid);

    always_ff @(posedge clk, negedge rst_n)
        begin
            if (!rst_n)
                burst_open <= 1'b0;
            else if (xfer)
                burst_open <= !out_last;
        end

    rr_arbiter u_rr_arbiter
        (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (req),
            .hold  (hold),
            .gnt   (gnt)
        );

endmodule : egress_merge

/* design/ingress_steer.sv */
`timescale 1ns/10ps

// Steers each ingress beat to the queue of its client
// Purely combinational, no clock needed
module ingress_steer
    (
        input  logic                   in_valid,
        output logic                   in_ready,
        input  mux_types_pkg::client_t in_client,
        input  mux_types_pkg::data_t   in_data,
        input  logic                   in_last,

        beat_if.src                    q [mux_cfg_pkg::NUM_CLIENTS]
    );

// ======================================================================
// Declarations

    // Ready of every queue gathered into one vector
    // Needed because an interface array takes only constant indices
    mux_types_pkg::client_mask_t q_ready;

// ======================================================================
// Per-queue fan-out

    for (genvar i = 0; i < mux_cfg_pkg::NUM_CLIENTS; i++)
        begin : g_steer

            // Valid only on the addressed queue
            assign q[i].valid = in_valid && (in_client == mux_types_pkg::client_t'(i));

            // Payload goes to every queue
            // Only the addressed one sees valid
            assign q[i].data = in_data;
            assign q[i].last = in_last;

            assign q_ready[i] = q[i].ready;

        end : g_steer

// ======================================================================
// Back-pressure

    // Stall follows the addressed queue only
    // A full queue blocks its own client and nobody else
    assign in_ready = q_ready[in_client];

endmodule : ingress_steer

/* design/mux_cfg_pkg.sv */
package mux_cfg_pkg;

    // ======================================================================
    // Size constants shared by the whole burst multiplexer
    // ======================================================================

    // Number of clients on the egress side, one queue each
    localparam int NUM_CLIENTS = 4;

    // Beats held per client queue
    localparam int QUEUE_DEPTH = 4;

    // Width of one data word
    localparam int DATA_W = 16;

    // Bits needed to name a client
    // Must cover NUM_CLIENTS
    localparam int CLIENT_W = 2;

endpackage : mux_cfg_pkg

/* design/mux_types_pkg.sv */
package mux_types_pkg;

    // ======================================================================
    // Vector types with a meaning of their own
    // ======================================================================

    // Client number as carried on the ingress and egress streams
    typedef logic [mux_cfg_pkg::CLIENT_W-1:0] client_t;

    // One payload word of a beat
    typedef logic [mux_cfg_pkg::DATA_W-1:0] data_t;

    // One bit per client
    // Used for requests, grants and the arbiter priority masks
    typedef logic [mux_cfg_pkg::NUM_CLIENTS-1:0] client_mask_t;

endpackage : mux_types_pkg

/* design/rr_arbiter.sv */
`timescale 1ns/10ps

// Round-robin arbiter with a registered one-hot grant
// Priority walks downward from the last winner and wraps to the top
module rr_arbiter
    (
        input  logic                        clk,
        input  logic                        rst_n,

        input  mux_types_pkg::client_mask_t req,
        input  logic                        hold,
        output mux_types_pkg::client_mask_t gnt
    );

// ======================================================================
// Declarations

    // Indices below the last winner
    mux_types_pkg::client_mask_t mask;
    // Everything except the last winner
    mux_types_pkg::client_mask_t win_mask_only;

    mux_types_pkg::client_mask_t req_masked;
    mux_types_pkg::client_mask_t req_win_mask;

    mux_types_pkg::client_t req_loc;
    mux_types_pkg::client_t reqm_loc;
    logic                   vld_req;
    logic                   vld_reqm;

    mux_types_pkg::client_t winner;
    logic                   win_vld;

// ======================================================================
// Search

    assign req_masked = req & mask;

    // A lone requester skips the winner mask
    // Otherwise it would be locked out after its own grant
    assign req_win_mask = ($countones(req) > 1) ? (req & win_mask_only) : req;

    assign {vld_req, req_loc}   = ffs(req_win_mask);
    assign {vld_reqm, reqm_loc} = ffs(req_masked);

    // Lower pending index first, else start over from the top
    always_comb
        begin
            if (vld_reqm)
                begin
                    winner  = reqm_loc;
                    win_vld = 1'b1;
                end
            else
                begin
                    winner  = req_loc;
                    win_vld = vld_req;
                end
        end

// ======================================================================
// State

    // Reset state searches from the highest index
    // Empty mask and open winner mask give a plain top-down search
    always_ff @(posedge clk, negedge rst_n)
        begin
            if (!rst_n)
                begin
                    gnt           <= '0;
                    mask          <= '0;
                    win_mask_only <= '1;
                end
            else if (!hold)
                begin
                    gnt <= win_vld ? onehot(winner) : '0;
                    // Pointer moves only with a real grant
                    if (win_vld)
                        begin
                            mask          <= onehot(winner) - 1'b1;
                            win_mask_only <= ~onehot(winner);
                        end
                end
        end

// ======================================================================
// Functions

    // Highest set bit of a vector, with a found flag on top
    function automatic logic [mux_cfg_pkg::CLIENT_W:0] ffs(
        input mux_types_pkg::client_mask_t vec);
        logic                   vld;
        mux_types_pkg::client_t loc;

        vld = 1'b0;
        loc = '0;
        for (int i = 0; i < mux_cfg_pkg::NUM_CLIENTS; i++)
            if (vec[i])
                begin
                    vld = 1'b1;
                    loc = mux_types_pkg::client_t'(i);
                end
        return {vld, loc};
    endfunction

    function automatic mux_types_pkg::client_mask_t onehot(input mux_types_pkg::client_t idx);
        return mux_types_pkg::client_mask_t'(1) << idx;
    endfunction

endmodule : rr_arbiter

/* sim.f */
design/mux_cfg_pkg.sv
design/mux_types_pkg.sv
design/beat_if.sv
design/ingress_steer.sv
design/client_queue.sv
design/rr_arbiter.sv
design/egress_merge.sv
design/burst_mux_top.sv
verif/burst_mux_chk.sv
verif/burst_mux_tb.sv

/* verif/burst_mux_chk.sv */
`timescale 1ns/10ps

// Protocol checks on the multiplexer's top-level streams
module burst_mux_chk
    (
        input logic                   clk,
        input logic                   rst_n,
        input logic                   in_ready,
        input logic                   out_valid,
        input logic                   out_ready,
        input mux_types_pkg::client_t out_client,
        input mux_types_pkg::data_t   out_data,
        input logic                   out_last
    );

    // Failed assertions so far, watched by the testbench
    int fail_count = 0;

    // Client of a burst that has started but not yet ended
    logic                   burst_open;
    mux_types_pkg::client_t open_client;

    always_ff @(posedge clk, negedge rst_n)
        begin
            if (!rst_n)
                begin
                    burst_open  <= 1'b0;
                    open_client <= '0;
                end
            else if (out_valid && out_ready)
                begin
                    burst_open  <= !out_last;
                    open_client <= out_client;
                end
        end

    // ======================================================================
    // Assertions
    // ======================================================================

    // Output idle and all queues open while reset is held
    assert property (@(posedge clk) !rst_n |-> !out_valid && in_ready)
        else
            begin
                $error("output valid or input stalled during reset");
                fail_count = fail_count + 1;
            end

    // Stalled output beat keeps every field
    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
            && $stable(out_client) && $stable(out_last))
        else
            begin
                $error("output beat changed while stalled");
                fail_count = fail_count + 1;
            end

    // No other client cuts into an open burst
    assert property (@(posedge clk) disable iff (!rst_n)
        burst_open && out_valid |-> out_client == open_client)
        else
            begin
                $error("burst interleaved with another client");
                fail_count = fail_count + 1;
            end

endmodule : burst_mux_chk

bind burst_mux_top burst_mux_chk u_burst_mux_chk
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_client (out_client),
        .out_data   (out_data),
        .out_last   (out_last)
    );

/* verif/burst_mux_tb.sv */
`timescale 1ns/10ps

// Testbench for the four-client burst multiplexer
module burst_mux_tb;

    // Edges allowed for any single wait
    localparam int WAIT_LIMIT = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    logic                   in_ready;
    mux_types_pkg::client_t in_client;
    mux_types_pkg::data_t   in_data;
    logic                   in_last;
    logic                   out_valid;
    logic                   out_ready;
    mux_types_pkg::client_t out_client;
    mux_types_pkg::data_t   out_data;
    logic                   out_last;

    int seed = 32'h2ff124a3;

    // Expected beats per client, last flag above the data word
    logic [mux_cfg_pkg::DATA_W:0] model_q [mux_cfg_pkg::NUM_CLIENTS][$];
    logic [mux_cfg_pkg::DATA_W:0] expected;
    // Client of each finished burst, in output order
    mux_types_pkg::client_t       burst_order [$];

    always #50 clk = ~clk;

    burst_mux_top u_burst_mux_top
        (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_valid   (in_valid),
            .in_ready   (in_ready),
            .in_client  (in_client),
            .in_data    (in_data),
            .in_last    (in_last),
            .out_valid  (out_valid),
            .out_ready  (out_ready),
            .out_client (out_client),
            .out_data   (out_data),
            .out_last   (out_last)
        );

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Holds one beat on the ingress until it is taken
    task automatic send_beat(input mux_types_pkg::client_t c, input mux_types_pkg::data_t d,
                             input logic l);
        int waited;

        waited    = 0;
        in_valid  = 1'b1;
        in_client = c;
        in_data   = d;
        in_last   = l;
        @(posedge clk);
        while (!in_ready)
            begin
                waited++;
                if (waited > WAIT_LIMIT)
                    stop_run("timeout waiting for in_ready");
                @(posedge clk);
            end
        model_q[c].push_back({l, d});
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_burst(input mux_types_pkg::client_t c, input int len);
        for (int i = 0; i < len; i++)
            send_beat(c, mux_types_pkg::data_t'(rand_below(65536)), i == len - 1);
    endtask

    // Sampled on the falling edge, clear of the monitor
    task automatic wait_drain();
        int   waited;
        logic busy;

        waited = 0;
        busy   = 1'b1;
        while (busy)
            begin
                @(negedge clk);
                busy = 1'b0;
                for (int c = 0; c < mux_cfg_pkg::NUM_CLIENTS; c++)
                    if (model_q[c].size() != 0)
                        busy = 1'b1;
                waited++;
                if (busy && waited > WAIT_LIMIT)
                    stop_run("timeout waiting for the queues to drain");
            end
        @(posedge clk);
        #1;
    endtask

    // ======================================================================
    // Output monitor against the reference queues
    // ======================================================================

    always @(posedge clk)
        begin
            if (rst_n && out_valid && out_ready)
                begin
                    assert (model_q[out_client].size() != 0)
                        else stop_run("output beat for a client with nothing sent");
                    expected = model_q[out_client].pop_front();
                    assert (out_data == expected[mux_cfg_pkg::DATA_W-1:0])
                        else stop_run($sformatf("mismatch at %0t: out_data expected %h actual %h",
                            $time, expected[mux_cfg_pkg::DATA_W-1:0], out_data));
                    assert (out_last == expected[mux_cfg_pkg::DATA_W])
                        else stop_run($sformatf("mismatch at %0t: out_last expected %b actual %b",
                            $time, expected[mux_cfg_pkg::DATA_W], out_last));
                    if (out_last)
                        burst_order.push_back(out_client);
                end
        end

    // Protocol assertions stop the run too
    always @(negedge clk)
        if (u_burst_mux_top.u_burst_mux_chk.fail_count != 0)
            stop_run("a protocol assertion in burst_mux_chk failed");

    // ======================================================================
    // Stimulus
    // ======================================================================

    initial
        begin
            int len_a;
            int len_b;

            clk       = 1'b0;
            rst_n     = 1'b0;
            in_valid  = 1'b0;
            in_client = '0;
            in_data   = '0;
            in_last   = 1'b0;
            out_ready = 1'b1;
            repeat (4) @(posedge clk);
            #1;
            rst_n = 1'b1;

            // Random bursts to random clients
            for (int b = 0; b < 12; b++)
                send_burst(mux_types_pkg::client_t'(rand_below(4)), 1 + rand_below(3));
            wait_drain();

            // Client 1 fills up, client 2 still passes
            out_ready = 1'b0;
            for (int i = 0; i < mux_cfg_pkg::QUEUE_DEPTH; i++)
                send_beat(2'd1, mux_types_pkg::data_t'(rand_below(65536)),
                          i == mux_cfg_pkg::QUEUE_DEPTH - 1);
            in_valid  = 1'b1;
            in_client = 2'd1;
            in_data   = mux_types_pkg::data_t'(rand_below(65536));
            in_last   = 1'b1;
            repeat (3)
                begin
                    @(posedge clk);
                    assert (!in_ready)
                        else stop_run($sformatf("mismatch at %0t: in_ready expected 0 actual %b",
                            $time, in_ready));
                end
            #1;
            in_client = 2'd2;
            @(posedge clk);
            assert (in_ready)
                else stop_run($sformatf("mismatch at %0t: in_ready expected 1 actual %b",
                    $time, in_ready));
            model_q[2].push_back({in_last, in_data});
            #1;
            in_valid  = 1'b0;
            out_ready = 1'b1;
            wait_drain();

            // Two rounds, one burst per client, loaded top index first
            for (int round = 0; round < 2; round++)
                begin
                    out_ready = 1'b0;
                    burst_order.delete();
                    for (int c = mux_cfg_pkg::NUM_CLIENTS - 1; c >= 0; c--)
                        send_burst(mux_types_pkg::client_t'(c), 1 + rand_below(3));
                    out_ready = 1'b1;
                    wait_drain();
                    assert (burst_order.size() == mux_cfg_pkg::NUM_CLIENTS)
                        else stop_run("wrong number of bursts in a round-robin round");
                    for (int k = 0; k < mux_cfg_pkg::NUM_CLIENTS; k++)
                        assert (burst_order[k] == mux_types_pkg::client_t'(3 - k))
                            else stop_run($sformatf(
                                "mismatch at %0t: out_client of burst %0d expected %0d actual %0d",
                                $time, k, 3 - k, burst_order[k]));
                end

            // Lone requester, two bursts back to back without a gap
            out_ready = 1'b0;
            len_a     = 1 + rand_below(3);
            len_b     = 1 + rand_below(mux_cfg_pkg::QUEUE_DEPTH - len_a);
            send_burst(2'd0, len_a);
            send_burst(2'd0, len_b);
            out_ready = 1'b1;
            for (int k = 0; k < len_a + len_b; k++)
                begin
                    @(posedge clk);
                    assert (out_valid)
                        else stop_run($sformatf("mismatch at %0t: out_valid expected 1 actual %b",
                            $time, out_valid));
                end
            wait_drain();

            if (u_burst_mux_top.u_burst_mux_chk.fail_count == 0)
                begin
                    $display("Simulation completed successfully");
                    $finish;
                end
            else
                stop_run("protocol assertions failed during the run");
        end

endmodule : burst_mux_tb
